// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lanzones
LOG       ?= sim.log
BUILD     ?= obj_dir

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): compile.f *.sv *.svh
	$(VERILATOR) --binary --timing -f compile.f --top-module $(TOP) -Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== aluWriteback.sv ====
`default_nettype none

module aluWriteback (
   input  wire logic                  clk,
   input  wire logic                  rstn,
   input  wire lanzonesPkg::opKind_t  opKind,
   input  wire lanzonesPkg::regIdx_t  rd,
   input  wire lanzonesPkg::word_t    imm,
   input  wire lanzonesPkg::word_t    rs1Data,
   input  wire lanzonesPkg::word_t    rs2Data,
   input  wire lanzonesPkg::word_t    memRData,
   input  wire logic                  loadDone,
   output lanzonesPkg::word_t         dataAddr,
   output lanzonesPkg::word_t         storeData,
   output logic                       regWEn,
   output lanzonesPkg::regIdx_t       regWAddr,
   output lanzonesPkg::word_t         regWData
);

   lanzonesPkg::word_t   addend;
   lanzonesPkg::word_t   sum;
   lanzonesPkg::regIdx_t loadRd; // destination of the outstanding load

   // one adder for ADD and for rs1 + imm addresses
   assign addend    = (opKind == lanzonesPkg::opAdd) ? rs2Data : imm;
   assign sum       = rs1Data + addend;
   assign dataAddr  = sum;
   assign storeData = rs2Data;

   always_ff @(posedge clk) begin
      if (opKind == lanzonesPkg::opLoad) begin
         loadRd <= rd;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         regWEn <= 1'b0;
      end else begin
         regWEn <= (opKind == lanzonesPkg::opLui) | (opKind == lanzonesPkg::opAdd) | loadDone;
      end
   end

   always_ff @(posedge clk) begin
      if (loadDone) begin
         regWAddr <= loadRd;
         regWData <= memRData;
      end else if (opKind == lanzonesPkg::opLui) begin
         regWAddr <= rd;
         regWData <= imm;
      end else if (opKind == lanzonesPkg::opAdd) begin
         regWAddr <= rd;
         regWData <= sum; // wraps at 32 bits
      end
   end

endmodule

`default_nettype wire

// ==== busSequencer.sv ====
`default_nettype none

module busSequencer (
   input  wire logic                  clk,
   input  wire logic                  rstn,
   input  wire logic                  launch,
   input  wire logic                  memVld,
   input  wire lanzonesPkg::word_t    memRData,
   input  wire lanzonesPkg::opKind_t  opKind,
   input  wire lanzonesPkg::word_t    dataAddr,
   input  wire lanzonesPkg::word_t    storeData,
   output logic                       memRdy,
   output lanzonesPkg::word_t         memAddr,
   output logic                       memWEn,
   output lanzonesPkg::word_t         memWData,
   output lanzonesPkg::word_t         instr,
   output logic                       instrValid,
   output logic                       loadDone,
   output logic                       halted
);

   typedef enum logic [1:0] {
      sHalted,
      sFetch,
      sDecode,
      sData
   } state_t;

   state_t             state;
   lanzonesPkg::word_t pc;
   logic               accept;

   assign accept     = memRdy & memVld; // memVld without a request is ignored
   assign instrValid = (state == sDecode);
   assign loadDone   = (state == sData) & accept & ~memWEn;
   assign halted     = (state == sHalted);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state  <= sHalted;
         pc     <= '0;
         memRdy <= 1'b0;
         memWEn <= 1'b0;
      end else begin
         case (state)
            sHalted: begin
               if (launch) begin
                  state <= sFetch;
               end
            end
            sFetch: begin
               if (!memRdy) begin
                  memRdy <= 1'b1; // request rises one cycle after entry
               end else if (memVld) begin
                  memRdy <= 1'b0;
                  pc     <= pc + 1'b1; // word index, not byte address
                  state  <= sDecode;
               end
            end
            sDecode: begin
               case (opKind)
                  lanzonesPkg::opStore, lanzonesPkg::opLoad: begin
                     memRdy <= 1'b1;
                     memWEn <= (opKind == lanzonesPkg::opStore);
                     state  <= sData;
                  end
                  lanzonesPkg::opHalt: begin
                     state <= sHalted; // pc already points past the halt
                  end
                  default: begin
                     state <= sFetch;
                  end
               endcase
            end
            sData: begin
               if (accept) begin
                  memRdy <= 1'b0;
                  memWEn <= 1'b0;
                  state  <= sFetch;
               end
            end
         endcase
      end
   end

   // request payload, held steady while memRdy is up
   always_ff @(posedge clk) begin
      if (state == sFetch && !memRdy) begin
         memAddr <= pc;
      end else if (state == sDecode) begin
         memAddr  <= dataAddr;
         memWData <= storeData;
      end
   end

   // instruction register
   always_ff @(posedge clk) begin
      if (state == sFetch && accept) begin
         instr <= memRData;
      end
   end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
lanzonesPkg.sv
busSequencer.sv
instrDecoder.sv
regFile.sv
aluWriteback.sv
lanzones.sv
tbChecker.sv
tb_lanzones.sv

// ==== instrDecoder.sv ====
`default_nettype none

`include "lanzones_macros.svh"

module instrDecoder (
   input  wire lanzonesPkg::word_t  instr,
   input  wire logic                instrValid,
   output lanzonesPkg::opKind_t     opKind,
   output lanzonesPkg::regIdx_t     rd,
   output lanzonesPkg::regIdx_t     rs1,
   output lanzonesPkg::regIdx_t     rs2,
   output lanzonesPkg::word_t       imm
);

   logic [6:0] opcode;

   assign opcode = instr[6:0];

   always_comb begin
      opKind = lanzonesPkg::opNone;
      rd     = '0;
      rs1    = '0;
      rs2    = '0;
      imm    = '0;
      if (instrValid) begin
         case (opcode)
            `OPC_LUI: begin
               opKind = lanzonesPkg::opLui;
               rd     = instr[11:7];
               imm    = {instr[31:12], 12'h000}; // U-type, already in place
            end
            `OPC_ADD: begin
               opKind = lanzonesPkg::opAdd;
               rd     = instr[11:7];
               rs1    = instr[19:15];
               rs2    = instr[24:20];
            end
            `OPC_STORE: begin
               opKind = lanzonesPkg::opStore;
               rs1    = instr[19:15];
               rs2    = instr[24:20];
               imm    = {20'h00000, instr[31:25], instr[11:7]};
            end
            `OPC_LOAD: begin
               // width field in [14:12] always gives a full word
               opKind = lanzonesPkg::opLoad;
               rd     = instr[11:7];
               rs1    = instr[19:15];
               imm    = {20'h00000, instr[31:20]}; // zero extended
            end
            `OPC_HALT: begin
               opKind = lanzonesPkg::opHalt;
            end
            default: begin
               opKind = lanzonesPkg::opNone; // treated as a no-op
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== lanzones.sv ====
`default_nettype none

module lanzones (
   input  wire logic                clk,
   input  wire logic                rstn,
   input  wire logic                launch,
   input  wire logic                memVld,
   input  wire lanzonesPkg::word_t  memRData,
   output logic                     memRdy,
   output lanzonesPkg::word_t       memAddr,
   output logic                     memWEn,
   output lanzonesPkg::word_t       memWData,
   output logic                     halted
);

   lanzonesPkg::word_t   instr;
   logic                 instrValid;
   logic                 loadDone;
   lanzonesPkg::opKind_t opKind;
   lanzonesPkg::regIdx_t rd;
   lanzonesPkg::regIdx_t rs1;
   lanzonesPkg::regIdx_t rs2;
   lanzonesPkg::word_t   imm;
   lanzonesPkg::word_t   rs1Data;
   lanzonesPkg::word_t   rs2Data;
   lanzonesPkg::word_t   dataAddr;
   lanzonesPkg::word_t   storeData;
   logic                 regWEn;
   lanzonesPkg::regIdx_t regWAddr;
   lanzonesPkg::word_t   regWData;

   busSequencer uSeq (
      .clk        (clk),
      .rstn       (rstn),
      .launch     (launch),
      .memVld     (memVld),
      .memRData   (memRData),
      .opKind     (opKind),
      .dataAddr   (dataAddr),
      .storeData  (storeData),
      .memRdy     (memRdy),
      .memAddr    (memAddr),
      .memWEn     (memWEn),
      .memWData   (memWData),
      .instr      (instr),
      .instrValid (instrValid),
      .loadDone   (loadDone),
      .halted     (halted)
   );

   instrDecoder uDec (
      .instr      (instr),
      .instrValid (instrValid),
      .opKind     (opKind),
      .rd         (rd),
      .rs1        (rs1),
      .rs2        (rs2),
      .imm        (imm)
   );

   regFile uRegs (
      .clk        (clk),
      .rstn       (rstn),
      .rs1        (rs1),
      .rs2        (rs2),
      .rs1Data    (rs1Data),
      .rs2Data    (rs2Data),
      .regWEn     (regWEn),
      .regWAddr   (regWAddr),
      .regWData   (regWData)
   );

   aluWriteback uAlu (
      .clk        (clk),
      .rstn       (rstn),
      .opKind     (opKind),
      .rd         (rd),
      .imm        (imm),
      .rs1Data    (rs1Data),
      .rs2Data    (rs2Data),
      .memRData   (memRData),
      .loadDone   (loadDone),
      .dataAddr   (dataAddr),
      .storeData  (storeData),
      .regWEn     (regWEn),
      .regWAddr   (regWAddr),
      .regWData   (regWData)
   );

endmodule

`default_nettype wire

// ==== lanzonesPkg.sv ====
`default_nettype none

`include "lanzones_macros.svh"

package lanzonesPkg;

   // data, address or instruction
   typedef logic [`XLEN-1:0] word_t;

   // register number
   typedef logic [`REG_IDX_W-1:0] regIdx_t;

   // what the decode cycle asks the rest of the core to do
   typedef enum logic [2:0] {
      opNone,  // unknown opcode or no instruction held
      opLui,
      opAdd,
      opStore,
      opLoad,
      opHalt
   } opKind_t;

endpackage

`default_nettype wire

// ==== lanzones_macros.svh ====
`ifndef LANZONES_MACROS_SVH
`define LANZONES_MACROS_SVH

// data path and instruction width
`define XLEN 32

// register file shape
`define REG_COUNT 32
`define REG_IDX_W 5

// major opcodes, bits [6:0] of the instruction
`define OPC_LUI   7'b0110111
`define OPC_ADD   7'b0110011
`define OPC_STORE 7'b0100011
`define OPC_LOAD  7'b0000011

// all ones stops the core until the next launch
`define OPC_HALT  7'b1111111

`endif

// ==== regFile.sv ====
`default_nettype none

`include "lanzones_macros.svh"

module regFile (
   input  wire logic                  clk,
   input  wire logic                  rstn,
   input  wire lanzonesPkg::regIdx_t  rs1,
   input  wire lanzonesPkg::regIdx_t  rs2,
   output lanzonesPkg::word_t         rs1Data,
   output lanzonesPkg::word_t         rs2Data,
   input  wire logic                  regWEn,
   input  wire lanzonesPkg::regIdx_t  regWAddr,
   input  wire lanzonesPkg::word_t    regWData
);

   lanzonesPkg::word_t regs [`REG_COUNT];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (regWEn && regWAddr != '0) begin
         regs[regWAddr] <= regWData; // x0 never written
      end
   end

   // x0 reads as zero
   assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
   assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== tbChecker.sv ====
`default_nettype none

`include "lanzones_macros.svh"

module tbChecker (
   input wire logic               clk,
   input wire logic               rstn,
   input wire logic               memRdy,
   input wire lanzonesPkg::word_t memAddr,
   input wire logic               memWEn,
   input wire lanzonesPkg::word_t memWData,
   input wire logic               memVld,
   input wire lanzonesPkg::word_t memRData,
   input wire logic               halted,
   input wire logic [31:0]        image [256]
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [31:0] regs [32];
   logic [31:0] cmem [256];
   logic [31:0] pc;
   logic        inData;     // waiting for the data access of a load or store
   logic        expWrite;
   logic [31:0] expAddr;
   logic [31:0] expData;
   logic [4:0]  expRd;
   int          haltCnt;
   logic        rstnQ;
   logic        prevRdy;
   logic        prevAcc;
   logic [31:0] prevAddr;
   logic        prevWEn;
   logic [31:0] prevWData;
   int          errCount = 0;
   int          errBase = 0;
   int          passCount = 0;
   int          failCount = 0;

   function automatic lanzonesPkg::opKind_t classify(input logic [31:0] w);
      case (w[6:0])
         `OPC_LUI:   return lanzonesPkg::opLui;
         `OPC_ADD:   return lanzonesPkg::opAdd;
         `OPC_STORE: return lanzonesPkg::opStore;
         `OPC_LOAD:  return lanzonesPkg::opLoad;
         `OPC_HALT:  return lanzonesPkg::opHalt;
         default:    return lanzonesPkg::opNone;
      endcase
   endfunction

   function automatic void mismatch(input string what, input logic [31:0] exp,
                                    input logic [31:0] act);
      $display("** Error at %0t: %s expected %h, got %h", $time, what, exp, act);
      errCount++;
   endfunction

   task automatic stepFetch(input logic [31:0] w);
      if (memAddr != pc) mismatch("fetch address", pc, memAddr);
      if (memWEn) mismatch("fetch write enable", 0, memWEn);
      pc = pc + 1;
      case (classify(w))
         lanzonesPkg::opLui: if (w[11:7] != 0) regs[w[11:7]] = {w[31:12], 12'h000};
         lanzonesPkg::opAdd:
            if (w[11:7] != 0) regs[w[11:7]] = regs[w[19:15]] + regs[w[24:20]];
         lanzonesPkg::opStore: begin
            inData   = 1'b1;
            expWrite = 1'b1;
            expAddr  = regs[w[19:15]] + {20'h0, w[31:25], w[11:7]};
            expData  = regs[w[24:20]];
         end
         lanzonesPkg::opLoad: begin
            inData   = 1'b1;
            expWrite = 1'b0;
            expAddr  = regs[w[19:15]] + {20'h0, w[31:20]};
            expRd    = w[11:7];
         end
         lanzonesPkg::opHalt: haltCnt = 2;
         default: ;
      endcase
   endtask

   task automatic finishData();
      inData = 1'b0;
      if (memAddr != expAddr) mismatch("data address", expAddr, memAddr);
      if (memWEn != expWrite) mismatch("data write enable", expWrite, memWEn);
      if (expWrite) begin
         if (memWData != expData) mismatch("store data", expData, memWData);
         cmem[expAddr[7:0]] = expData;
      end else begin
         if (memRData != cmem[expAddr[7:0]]) mismatch("load data", cmem[expAddr[7:0]], memRData);
         if (expRd != 0) regs[expRd] = cmem[expAddr[7:0]];
      end
   endtask

   always @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < 32; i++) regs[i] = '0;
         for (int i = 0; i < 256; i++) cmem[i] = image[i];
         pc      = '0;
         inData  = 1'b0;
         haltCnt = 0;
         prevRdy = 1'b0;
         prevAcc = 1'b0;
      end else begin
         if (!rstnQ && !halted) mismatch("halted after reset", 1, halted);
         if (halted && memRdy) mismatch("request while halted", 0, memRdy);
         if (prevAcc && memRdy) mismatch("request low after response", 0, memRdy);
         if (prevRdy && memRdy && !prevAcc) begin // request must hold still
            if (memAddr != prevAddr) mismatch("held address", prevAddr, memAddr);
            if (memWEn != prevWEn) mismatch("held write enable", prevWEn, memWEn);
            if (memWEn && memWData != prevWData) mismatch("held write data", prevWData, memWData);
         end
         if (haltCnt > 0) begin
            haltCnt--;
            if (haltCnt == 0 && !halted) mismatch("halted after halt opcode", 1, halted);
         end
         if (memRdy && memVld) begin
            if (inData) finishData();
            else stepFetch(memRData);
         end
         prevRdy   = memRdy;
         prevAcc   = memRdy & memVld;
         prevAddr  = memAddr;
         prevWEn   = memWEn;
         prevWData = memWData;
      end
      rstnQ = rstn;
   end

   task automatic endTest(input string name);
      if (errCount == errBase) begin
         passCount++;
         $display("test %s: passed", name);
      end else begin
         failCount++;
         $display("test %s: failed with %0d errors", name, errCount - errBase);
      end
      errBase = errCount;
   endtask

endmodule

`default_nettype wire

// ==== tb_lanzones.sv ====
`default_nettype none

`include "lanzones_macros.svh"

module tb_lanzones;
   timeunit 1ns;
   timeprecision 1ps;

   logic               clk;
   logic               rstn;
   logic               launch;
   logic               memVld = 1'b0;
   lanzonesPkg::word_t memRData = '0;
   logic               memRdy;
   lanzonesPkg::word_t memAddr;
   logic               memWEn;
   lanzonesPkg::word_t memWData;
   logic               halted;

   logic [31:0] prog [256]; // image copied into memory during reset
   logic [31:0] mem [256];
   integer      seed;
   int          lat;
   logic        busy;

   lanzones uut (
      .clk      (clk),
      .rstn     (rstn),
      .launch   (launch),
      .memVld   (memVld),
      .memRData (memRData),
      .memRdy   (memRdy),
      .memAddr  (memAddr),
      .memWEn   (memWEn),
      .memWData (memWData),
      .halted   (halted)
   );

   tbChecker chk (
      .clk      (clk),
      .rstn     (rstn),
      .memRdy   (memRdy),
      .memAddr  (memAddr),
      .memWEn   (memWEn),
      .memWData (memWData),
      .memVld   (memVld),
      .memRData (memRData),
      .halted   (halted),
      .image    (prog)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   // memory model, answers after 1 to 5 cycles
   always @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < 256; i++) begin
            mem[i] <= prog[i];
         end
         memVld <= 1'b0;
         busy   <= 1'b0;
      end else if (memVld) begin
         memVld <= 1'b0;
         busy   <= 1'b0;
      end else if (memRdy && !busy) begin
         busy <= 1'b1;
         lat  <= $unsigned($random(seed)) % 5;
      end else if (busy && lat != 0) begin
         lat <= lat - 1;
      end else if (busy) begin
         memVld <= 1'b1;
         if (memWEn) begin
            mem[memAddr[7:0]] <= memWData;
         end else begin
            memRData <= mem[memAddr[7:0]];
         end
      end
   end

   function automatic logic [31:0] encLui(input logic [4:0] rd, input logic [19:0] imm);
      return {imm, rd, `OPC_LUI};
   endfunction

   function automatic logic [31:0] encAdd(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
      return {7'h00, rs2, rs1, 3'b000, rd, `OPC_ADD};
   endfunction

   function automatic logic [31:0] encStore(input logic [4:0] rs1, input logic [4:0] rs2,
                                            input logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OPC_STORE};
   endfunction

   function automatic logic [31:0] encLoad(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
      return {imm, rs1, 3'b010, rd, `OPC_LOAD};
   endfunction

   // mode 0 arithmetic and stores, 1 loads and stores, 2 everything
   task automatic buildProgram(input int mode, input int haltAt);
      int          kind;
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [4:0]  base;
      logic [11:0] dAddr;
      for (int i = 0; i < 256; i++) begin
         if (i >= 128 && i < 192) prog[i] = $random(seed); // data region
         else prog[i] = {25'h0, `OPC_HALT};
      end
      for (int i = 0; i < 48; i++) begin
         kind  = $unsigned($random(seed)) % 5;
         ra    = $unsigned($random(seed)) % 8; // x0 included on purpose
         rb    = $unsigned($random(seed)) % 8;
         base  = ($random(seed) & 1) ? 5'd8 : 5'd0; // x8 only ever holds an upper immediate
         dAddr = 12'd128 + ($unsigned($random(seed)) % 64);
         if (mode == 0 && kind == 1) kind = 2;
         if (mode == 1 && kind == 2) kind = 1;
         if (i == haltAt) prog[i] = {25'h0, `OPC_HALT};
         else if (i == 0) prog[i] = encLui(5'd8, $random(seed)); // low 12 bits stay clear
         else if (kind == 0) prog[i] = encLui(ra, $random(seed));
         else if (kind == 1) prog[i] = encLoad(ra, base, dAddr);
         else if (kind == 2) prog[i] = encAdd(ra, rb, ($unsigned($random(seed)) % 8));
         else prog[i] = encStore(base, rb, dAddr);
      end
   endtask

   task automatic resetDut();
      repeat (3) begin
         @(posedge clk);
         rstn <= 1'b0;
      end
      @(posedge clk);
      rstn <= 1'b1;
      repeat (4) @(posedge clk); // idle window, no request allowed
   endtask

   task automatic pulseLaunch();
      @(posedge clk);
      launch <= 1'b1;
      @(posedge clk);
      launch <= 1'b0;
   endtask

   task automatic waitForHalt(input string what);
      int n;
      n = 0;
      @(negedge clk);
      while (halted) begin
         @(negedge clk);
         n++;
         if (n > 100) begin
            $display("timeout: the core never left halt after launch in %s", what);
            $display("STATUS: FAIL");
            $finish;
         end
      end
      n = 0;
      while (!halted || chk.haltCnt != 0) begin
         @(negedge clk);
         n++;
         if (n > 20000) begin
            $display("timeout: the program in %s never reached its halt", what);
            $display("STATUS: FAIL");
            $finish;
         end
      end
   endtask

   task automatic runTest(input string name, input int mode, input int haltAt);
      buildProgram(mode, haltAt);
      resetDut();
      pulseLaunch();
      waitForHalt(name);
      if (haltAt >= 0) begin
         pulseLaunch(); // resume after the mid-program halt
         waitForHalt(name);
      end
      chk.endTest(name);
   endtask

   initial begin
      seed   = 59790;
      rstn   = 1'b0;
      launch = 1'b0;
      runTest("reset_and_launch", 2, -1);
      runTest("sequential_fetch", 2, -1);
      runTest("lui_add_store", 0, -1);
      runTest("load_then_store", 1, -1);
      runTest("halt_and_resume", 2, 20);
      $display("tests: %0d passed, %0d failed", chk.passCount, chk.failCount);
      if (chk.failCount == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
